// ==== build.f ====
logic/mfp_pkg.sv
logic/mfp_ahb_decoder.sv
logic/mfp_ahb_ram.sv
logic/mfp_ahb_gpio.sv
logic/mfp_ahb_read_mux.sv
logic/mfp_als_spi_receiver.sv
logic/mfp_ahb_lite_system.sv
testbench/tb_als_sensor.sv
testbench/tb_mfp_system.sv

// ==== logic/mfp_ahb_decoder.sv ====
module mfp_ahb_decoder
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          haddr,
    input  logic [1:0]           htrans,
    input  logic [2:0]           hsize,
    input  logic                 hwrite,
    output mfp_pkg::ahb_access_t addr_phase,
    output mfp_pkg::ahb_access_t data_phase
);

    import mfp_pkg::*;

    logic    active;
    target_t target;

    // only NONSEQ and SEQ start a transfer
    assign active = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

    always_comb
    begin
        if (!active)
            target = tgt_none;
        else if (haddr[31:28] == RAM_BASE[31:28])
            target = tgt_ram;
        else if (haddr[31:12] == GPIO_BASE[31:12])
            target = tgt_gpio;
        else
            target = tgt_none;
    end

    always_comb
    begin
        addr_phase.valid  = active;
        addr_phase.target = target;
        addr_phase.write  = hwrite;
        addr_phase.size   = hsize;
        addr_phase.addr   = haddr;
    end

    // address phase moves into the data phase on every clock
    always_ff @(posedge clk)
    begin
        if (rst)
            data_phase <= '0;
        else
            data_phase <= addr_phase;
    end

endmodule

// ==== logic/mfp_ahb_gpio.sv ====
module mfp_ahb_gpio
(
    input  logic                                clk,
    input  logic                                rst,
    input  mfp_pkg::ahb_access_t                addr_phase,
    input  mfp_pkg::ahb_access_t                data_phase,
    input  logic [31:0]                         hwdata,
    input  logic [mfp_pkg::SWITCH_WIDTH-1:0]    switches,
    input  logic [mfp_pkg::BUTTON_WIDTH-1:0]    buttons,
    input  logic [mfp_pkg::LIGHT_WIDTH-1:0]     light_value,
    output logic [mfp_pkg::RED_LED_WIDTH-1:0]   red_leds,
    output logic [mfp_pkg::GREEN_LED_WIDTH-1:0] green_leds,
    output logic [31:0]                         gpio_rdata
);

    import mfp_pkg::*;

    logic wr_en;
    logic rd_en;

    assign wr_en = data_phase.valid && (data_phase.target == tgt_gpio) && data_phase.write;
    assign rd_en = addr_phase.valid && (addr_phase.target == tgt_gpio) && !addr_phase.write;

    // led registers take the low bits of the word, size is ignored
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            red_leds   <= '0;
            green_leds <= '0;
        end
        else if (wr_en)
        begin
            case (data_phase.addr[11:0])
                GPIO_RED_LEDS:   red_leds   <= hwdata[RED_LED_WIDTH-1:0];
                GPIO_GREEN_LEDS: green_leds <= hwdata[GREEN_LED_WIDTH-1:0];
                default:         ;
            endcase
        end
    end

    // inputs are sampled at the address phase
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            case (addr_phase.addr[11:0])
                GPIO_RED_LEDS:   gpio_rdata <= 32'(red_leds);
                GPIO_GREEN_LEDS: gpio_rdata <= 32'(green_leds);
                GPIO_SWITCHES:   gpio_rdata <= 32'(switches);
                GPIO_BUTTONS:    gpio_rdata <= 32'(buttons);
                GPIO_LIGHT:      gpio_rdata <= 32'(light_value);
                default:         gpio_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== logic/mfp_ahb_lite_system.sv ====
module mfp_ahb_lite_system
#(
    parameter int RAM_ADDR_WIDTH = mfp_pkg::DEFAULT_RAM_ADDR_WIDTH,
    parameter int SPI_CLK_DIV    = mfp_pkg::DEFAULT_SPI_CLK_DIV,
    parameter int SPI_GAP        = mfp_pkg::DEFAULT_SPI_GAP
)
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [31:0]                         haddr,
    input  logic [1:0]                          htrans,
    input  logic [2:0]                          hsize,
    input  logic                                hwrite,
    input  logic [31:0]                         hwdata,
    output logic [31:0]                         hrdata,
    input  logic [mfp_pkg::SWITCH_WIDTH-1:0]    switches,
    input  logic [mfp_pkg::BUTTON_WIDTH-1:0]    buttons,
    output logic [mfp_pkg::RED_LED_WIDTH-1:0]   red_leds,
    output logic [mfp_pkg::GREEN_LED_WIDTH-1:0] green_leds,
    output logic                                spi_cs,
    output logic                                spi_sck,
    input  logic                                spi_sdo
);

    import mfp_pkg::*;

    ahb_access_t            addr_phase;
    ahb_access_t            data_phase;
    logic [31:0]            ram_rdata;
    logic [31:0]            gpio_rdata;
    logic [LIGHT_WIDTH-1:0] light_value;

    // decode
    mfp_ahb_decoder decoder
    (
        .clk        (clk),
        .rst        (rst),
        .haddr      (haddr),
        .htrans     (htrans),
        .hsize      (hsize),
        .hwrite     (hwrite),
        .addr_phase (addr_phase),
        .data_phase (data_phase)
    );

    // execute
    mfp_ahb_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) ram
    (
        .clk        (clk),
        .addr_phase (addr_phase),
        .data_phase (data_phase),
        .hwdata     (hwdata),
        .ram_rdata  (ram_rdata)
    );

    mfp_ahb_gpio gpio
    (
        .clk         (clk),
        .rst         (rst),
        .addr_phase  (addr_phase),
        .data_phase  (data_phase),
        .hwdata      (hwdata),
        .switches    (switches),
        .buttons     (buttons),
        .light_value (light_value),
        .red_leds    (red_leds),
        .green_leds  (green_leds),
        .gpio_rdata  (gpio_rdata)
    );

    // result
    mfp_ahb_read_mux read_mux
    (
        .data_phase (data_phase),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .hrdata     (hrdata)
    );

    // light sensor readings land in the gpio light register
    mfp_als_spi_receiver #(.SPI_CLK_DIV(SPI_CLK_DIV), .SPI_GAP(SPI_GAP)) als_receiver
    (
        .clk         (clk),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_sck     (spi_sck),
        .spi_sdo     (spi_sdo),
        .light_value (light_value)
    );

endmodule

// ==== logic/mfp_ahb_ram.sv ====
module mfp_ahb_ram
#(
    parameter int RAM_ADDR_WIDTH = mfp_pkg::DEFAULT_RAM_ADDR_WIDTH
)
(
    input  logic                 clk,
    input  mfp_pkg::ahb_access_t addr_phase,
    input  mfp_pkg::ahb_access_t data_phase,
    input  logic [31:0]          hwdata,
    output logic [31:0]          ram_rdata
);

    import mfp_pkg::*;

    logic [31:0] mem [2**RAM_ADDR_WIDTH];

    logic                      wr_en;
    logic                      rd_en;
    logic                      same_word;
    logic [3:0]                wr_be;
    logic [RAM_ADDR_WIDTH-1:0] wr_index;
    logic [RAM_ADDR_WIDTH-1:0] rd_index;

    assign wr_en    = data_phase.valid && (data_phase.target == tgt_ram) && data_phase.write;
    assign rd_en    = addr_phase.valid && (addr_phase.target == tgt_ram) && !addr_phase.write;
    assign wr_index = data_phase.addr[RAM_ADDR_WIDTH+1:2];
    assign rd_index = addr_phase.addr[RAM_ADDR_WIDTH+1:2];

    // read hits the word being written this cycle
    assign same_word = wr_en && (wr_index == rd_index);

    // little-endian lanes
    always_comb
    begin
        case (data_phase.size)
            HSIZE_BYTE: wr_be = 4'b0001 << data_phase.addr[1:0];
            HSIZE_HALF: wr_be = data_phase.addr[1] ? 4'b1100 : 4'b0011;
            default:    wr_be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (wr_en && wr_be[i])
                mem[wr_index][8*i +: 8] <= hwdata[8*i +: 8];

            if (rd_en)
            begin
                if (same_word && wr_be[i])
                    ram_rdata[8*i +: 8] <= hwdata[8*i +: 8];
                else
                    ram_rdata[8*i +: 8] <= mem[rd_index][8*i +: 8];
            end
        end
    end

endmodule

// ==== logic/mfp_ahb_read_mux.sv ====
module mfp_ahb_read_mux
(
    input  mfp_pkg::ahb_access_t data_phase,
    input  logic [31:0]          ram_rdata,
    input  logic [31:0]          gpio_rdata,
    output logic [31:0]          hrdata
);

    import mfp_pkg::*;

    logic is_read;

    assign is_read = data_phase.valid && !data_phase.write;

    // unmapped space, writes and idle cycles return zero
    always_comb
    begin
        hrdata = '0;
        if (is_read)
        begin
            case (data_phase.target)
                tgt_ram:  hrdata = ram_rdata;
                tgt_gpio: hrdata = gpio_rdata;
                default:  hrdata = '0;
            endcase
        end
    end

endmodule

// ==== logic/mfp_als_spi_receiver.sv ====
module mfp_als_spi_receiver
#(
    parameter int SPI_CLK_DIV = mfp_pkg::DEFAULT_SPI_CLK_DIV,
    parameter int SPI_GAP     = mfp_pkg::DEFAULT_SPI_GAP
)
(
    input  logic                            clk,
    input  logic                            rst,
    output logic                            spi_cs,
    output logic                            spi_sck,
    input  logic                            spi_sdo,
    output logic [mfp_pkg::LIGHT_WIDTH-1:0] light_value
);

    import mfp_pkg::*;

    localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);
    localparam int GAP_W = $clog2(SPI_GAP + 1);

    logic [DIV_W-1:0]       div_cnt;
    logic [GAP_W-1:0]       gap_cnt;
    logic [4:0]             half_cnt;
    logic [LIGHT_WIDTH-1:0] shift_reg;
    logic                   half_done;

    assign half_done = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            spi_cs      <= 1'b1;
            spi_sck     <= 1'b0;
            div_cnt     <= '0;
            gap_cnt     <= '0;
            half_cnt    <= '0;
            light_value <= '0;
        end
        else if (spi_cs)
        begin
            // idle gap, then open the next frame
            if (gap_cnt == GAP_W'(SPI_GAP - 1))
            begin
                gap_cnt <= '0;
                spi_cs  <= 1'b0;
            end
            else
                gap_cnt <= gap_cnt + 1'b1;
        end
        else if (half_done)
        begin
            div_cnt  <= '0;
            spi_sck  <= ~spi_sck;
            half_cnt <= half_cnt + 1'b1;
            // sck about to rise, sdo is stable here
            if (!spi_sck)
                shift_reg <= {shift_reg[LIGHT_WIDTH-2:0], spi_sdo};
            // 32 half periods make one frame
            if (half_cnt == 5'd31)
            begin
                spi_cs      <= 1'b1;
                light_value <= shift_reg;
            end
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

endmodule

// ==== logic/mfp_pkg.sv ====
package mfp_pkg;

    // AHB-Lite transfer types
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // transfer sizes
    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    typedef enum logic [1:0]
    {
        tgt_none,
        tgt_ram,
        tgt_gpio
    } target_t;

    typedef struct packed
    {
        logic        valid;
        target_t     target;
        logic        write;
        logic [2:0]  size;
        logic [31:0] addr;
    } ahb_access_t;

    // address map
    localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
    localparam logic [31:0] GPIO_BASE = 32'h1F80_0000;

    // gpio register offsets
    localparam logic [11:0] GPIO_RED_LEDS   = 12'h000;
    localparam logic [11:0] GPIO_GREEN_LEDS = 12'h004;
    localparam logic [11:0] GPIO_SWITCHES   = 12'h008;
    localparam logic [11:0] GPIO_BUTTONS    = 12'h00C;
    localparam logic [11:0] GPIO_LIGHT      = 12'h014;

    // board pins
    localparam int SWITCH_WIDTH    = 18;
    localparam int BUTTON_WIDTH    = 5;
    localparam int RED_LED_WIDTH   = 18;
    localparam int GREEN_LED_WIDTH = 9;
    localparam int LIGHT_WIDTH     = 16;

    // default values of the system parameters
    localparam int DEFAULT_RAM_ADDR_WIDTH = 10;
    localparam int DEFAULT_SPI_CLK_DIV    = 4;
    localparam int DEFAULT_SPI_GAP        = 8;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mfp_system -f build.f -o tb_mfp_system

output=$(./obj_dir/tb_mfp_system)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== testbench/tb_als_sensor.sv ====
module tb_als_sensor
#(
    parameter int                                         FRAME_COUNT = 1,
    parameter logic [FRAME_COUNT*mfp_pkg::LIGHT_WIDTH-1:0] FRAMES     = '0
)
(
    input  logic clk,
    input  logic spi_cs,
    input  logic spi_sck,
    output logic spi_sdo
);

    import mfp_pkg::*;

    logic [LIGHT_WIDTH-1:0] frame;
    int                     frame_index;

    // frames go out in table order and wrap around
    initial
    begin
        spi_sdo     = 1'b0;
        frame_index = 0;
        forever
        begin
            @(negedge spi_cs);
            frame = FRAMES[frame_index*LIGHT_WIDTH +: LIGHT_WIDTH];
            // msb one clock after cs falls
            @(posedge clk);
            spi_sdo <= frame[LIGHT_WIDTH-1];
            for (int b = LIGHT_WIDTH - 2; b >= 0; b--)
            begin
                @(negedge spi_sck);
                spi_sdo <= frame[b];
            end
            @(posedge spi_cs);
            frame_index = (frame_index + 1) % FRAME_COUNT;
        end
    end

endmodule

// ==== testbench/tb_mfp_system.sv ====
module tb_mfp_system;

    import mfp_pkg::*;

    localparam int SPI_CLK_DIV = 2;
    localparam int SPI_GAP     = 4;
    localparam int FRAME_LEN   = 32 * SPI_CLK_DIV + SPI_GAP;
    localparam int FRAME_COUNT = 3;
    // frame 0 in the low bits
    localparam logic [FRAME_COUNT*LIGHT_WIDTH-1:0] LIGHT_FRAMES =
        {16'hF00D, 16'h03C4, 16'h1A2B};

    typedef struct packed
    {
        logic [31:0]                addr;
        logic [2:0]                 size;
        logic                       write;
        logic [31:0]                data;
        logic [31:0]                rdata;
        logic [RED_LED_WIDTH-1:0]   red;
        logic [GREEN_LED_WIDTH-1:0] green;
    } row_t;

    logic                       clk;
    logic                       rst;
    logic [31:0]                haddr;
    logic [1:0]                 htrans;
    logic [2:0]                 hsize;
    logic                       hwrite;
    logic [31:0]                hwdata;
    logic [31:0]                hrdata;
    logic [SWITCH_WIDTH-1:0]    switches;
    logic [BUTTON_WIDTH-1:0]    buttons;
    logic [RED_LED_WIDTH-1:0]   red_leds;
    logic [GREEN_LED_WIDTH-1:0] green_leds;
    logic                       spi_cs;
    logic                       spi_sck;
    logic                       spi_sdo;

    row_t                       rows[$];
    logic [31:0]                ram_model [int];
    logic [RED_LED_WIDTH-1:0]   model_red;
    logic [GREEN_LED_WIDTH-1:0] model_green;
    logic [SWITCH_WIDTH-1:0]    sw_value;
    logic [BUTTON_WIDTH-1:0]    btn_value;
    int                         error_count;
    int                         check_count;
    int                         test_count;
    int                         failed_tests;
    int                         errors_at_start;
    bit                         table_ready;

    mfp_ahb_lite_system #(.SPI_CLK_DIV(SPI_CLK_DIV), .SPI_GAP(SPI_GAP)) DUT
    (
        .clk        (clk),
        .rst        (rst),
        .haddr      (haddr),
        .htrans     (htrans),
        .hsize      (hsize),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_sdo    (spi_sdo)
    );

    tb_als_sensor #(.FRAME_COUNT(FRAME_COUNT), .FRAMES(LIGHT_FRAMES)) sensor
    (
        .clk     (clk),
        .spi_cs  (spi_cs),
        .spi_sck (spi_sck),
        .spi_sdo (spi_sdo)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_leds(input logic [RED_LED_WIDTH-1:0] got_red,
                              input logic [GREEN_LED_WIDTH-1:0] got_green,
                              input logic [RED_LED_WIDTH-1:0] exp_red,
                              input logic [GREEN_LED_WIDTH-1:0] exp_green);
        check_count += 2;
        if (got_red !== exp_red)
        begin
            error_count++;
            $display("MISMATCH at %0t: red_leds got %h expected %h", $time, got_red, exp_red);
        end
        if (got_green !== exp_green)
        begin
            error_count++;
            $display("MISMATCH at %0t: green_leds got %h expected %h",
                     $time, got_green, exp_green);
        end
    endtask

    task automatic check_light(input logic [31:0] got, input logic [LIGHT_WIDTH-1:0] frame);
        check_count++;
        if (got !== 32'(frame))
        begin
            error_count++;
            $display("MISMATCH at %0t: hrdata (light) got %h expected %h",
                     $time, got, 32'(frame));
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_at_start)
            $display("%s: ok", name);
        else
        begin
            failed_tests++;
            $display("%s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    // little-endian lanes touched by a write
    function automatic logic [31:0] lane_mask(input logic [2:0] size, input logic [1:0] low);
        if (size == HSIZE_BYTE)
            return 32'h0000_00FF << (8 * low);
        else if (size == HSIZE_HALF)
            return low[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
        return 32'hFFFF_FFFF;
    endfunction

    function automatic logic [31:0] gpio_addr(input logic [11:0] offset);
        return {GPIO_BASE[31:12], offset};
    endfunction

    // appends a row and works out its expected read word and led state
    task automatic add_row(input logic [31:0] addr, input logic [2:0] size,
                           input logic write, input logic [31:0] data);
        row_t        row;
        logic [31:0] mask;
        logic [31:0] old;
        logic [31:0] rdata;
        int          index;
        mask  = lane_mask(size, addr[1:0]);
        index = int'(addr[11:2]);
        rdata = '0;
        if (addr[31:28] == RAM_BASE[31:28])
        begin
            old = ram_model.exists(index) ? ram_model[index] : 32'h0;
            if (write)
                ram_model[index] = (old & ~mask) | (data & mask);
            else
                rdata = old;
        end
        else if (addr[31:12] == GPIO_BASE[31:12])
        begin
            if (write && addr[11:0] == GPIO_RED_LEDS)
                model_red = data[RED_LED_WIDTH-1:0];
            else if (write && addr[11:0] == GPIO_GREEN_LEDS)
                model_green = data[GREEN_LED_WIDTH-1:0];
            else if (!write)
            begin
                case (addr[11:0])
                    GPIO_RED_LEDS:   rdata = 32'(model_red);
                    GPIO_GREEN_LEDS: rdata = 32'(model_green);
                    GPIO_SWITCHES:   rdata = 32'(sw_value);
                    GPIO_BUTTONS:    rdata = 32'(btn_value);
                    default:         rdata = '0;
                endcase
            end
        end
        row = '{addr, size, write, data, rdata, model_red, model_green};
        rows.push_back(row);
    endtask

    // rows go out back to back with each data phase under the next address phase
    task automatic run_rows(input int first, input int last);
        int   n;
        row_t cur;
        row_t prev;
        row_t led_row;
        n = last - first;
        for (int i = 0; i <= n + 1; i++)
        begin
            @(posedge clk);
            if (i < n)
            begin
                cur = rows[first + i];
                haddr  <= cur.addr;
                htrans <= HTRANS_NONSEQ;
                hsize  <= cur.size;
                hwrite <= cur.write;
            end
            else
                htrans <= HTRANS_IDLE;
            if (i >= 1 && i <= n)
            begin
                prev = rows[first + i - 1];
                hwdata <= prev.write ? prev.data : 32'h0;
            end
            else
                hwdata <= '0;
            @(negedge clk);
            if (i >= 1 && i <= n)
                check_word($sformatf("hrdata row %0d", first + i - 1), hrdata, prev.rdata);
            // leds follow a write one clock after its data phase
            if (i >= 2)
            begin
                led_row = rows[first + i - 2];
                check_leds(red_leds, green_leds, led_row.red, led_row.green);
            end
        end
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] got);
        @(posedge clk);
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        hsize  <= HSIZE_WORD;
        hwrite <= 1'b0;
        @(posedge clk);
        htrans <= HTRANS_IDLE;
        @(negedge clk);
        got = hrdata;
    endtask

    // reads the light register every clock until the frame shows or time runs out
    task automatic poll_light(input logic [LIGHT_WIDTH-1:0] frame, input int limit,
                              output logic [31:0] got);
        int n;
        n = 0;
        @(posedge clk);
        haddr  <= gpio_addr(GPIO_LIGHT);
        htrans <= HTRANS_NONSEQ;
        hsize  <= HSIZE_WORD;
        hwrite <= 1'b0;
        do
        begin
            @(posedge clk);
            @(negedge clk);
            got = hrdata;
            n++;
        end
        while (got !== 32'(frame) && n < limit);
        @(posedge clk);
        htrans <= HTRANS_IDLE;
    endtask

    initial
    begin
        logic [31:0] got;
        int          words_end;
        int          lanes_end;
        int          bypass_end;
        rst         = 1'b1;
        haddr       = '0;
        htrans      = HTRANS_IDLE;
        hsize       = HSIZE_WORD;
        hwrite      = 1'b0;
        hwdata      = '0;
        switches    = '0;
        buttons     = '0;
        model_red   = '0;
        model_green = '0;
        void'($urandom(18669));
        sw_value  = SWITCH_WIDTH'($urandom());
        btn_value = BUTTON_WIDTH'($urandom());

        // ram words
        add_row(32'h0000_0000, HSIZE_WORD, 1'b1, 32'h0123_4567);
        add_row(32'h0000_0004, HSIZE_WORD, 1'b1, 32'h89AB_CDEF);
        add_row(32'h0000_03FC, HSIZE_WORD, 1'b1, 32'h5A5A_0F0F);
        add_row(32'h0000_0FFC, HSIZE_WORD, 1'b1, 32'hC0FF_EE00);
        add_row(32'h0000_0004, HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_0000, HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_0FFC, HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_03FC, HSIZE_WORD, 1'b0, 32'h0);
        words_end = rows.size();
        // byte and halfword merges with junk in the unused lanes
        add_row(32'h0000_0100, HSIZE_WORD, 1'b1, 32'h1122_3344);
        add_row(32'h0000_0101, HSIZE_BYTE, 1'b1, 32'hFFFF_ABFF);
        add_row(32'h0000_0102, HSIZE_HALF, 1'b1, 32'hBEEF_FFFF);
        add_row(32'h0000_0100, HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_0104, HSIZE_WORD, 1'b1, 32'hA5A5_A5A5);
        add_row(32'h0000_0107, HSIZE_BYTE, 1'b1, 32'h77FF_FFFF);
        add_row(32'h0000_0104, HSIZE_HALF, 1'b1, 32'hFFFF_1234);
        add_row(32'h0000_0104, HSIZE_WORD, 1'b0, 32'h0);
        lanes_end = rows.size();
        // each read overlaps the data phase of the write before it
        add_row(32'h0000_0200, HSIZE_WORD, 1'b1, 32'hDEAD_BEEF);
        add_row(32'h0000_0200, HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_0201, HSIZE_BYTE, 1'b1, 32'h0000_5A00);
        add_row(32'h0000_0200, HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_0206, HSIZE_HALF, 1'b1, 32'h7E57_0000);
        add_row(32'h0000_0204, HSIZE_WORD, 1'b0, 32'h0);
        bypass_end = rows.size();
        // gpio readbacks kept two rows behind their writes
        add_row(gpio_addr(GPIO_RED_LEDS), HSIZE_WORD, 1'b1, 32'hFFFF_FFFF);
        add_row(gpio_addr(GPIO_GREEN_LEDS), HSIZE_WORD, 1'b1, 32'h0000_0ABC);
        add_row(gpio_addr(GPIO_RED_LEDS), HSIZE_WORD, 1'b0, 32'h0);
        add_row(gpio_addr(GPIO_GREEN_LEDS), HSIZE_WORD, 1'b0, 32'h0);
        add_row(gpio_addr(GPIO_SWITCHES), HSIZE_WORD, 1'b0, 32'h0);
        add_row(gpio_addr(GPIO_BUTTONS), HSIZE_WORD, 1'b0, 32'h0);
        add_row(gpio_addr(12'h010), HSIZE_WORD, 1'b1, 32'h1234_5678);
        add_row(32'h2000_0000, HSIZE_WORD, 1'b1, 32'hFFFF_FFFF);
        add_row(gpio_addr(12'h010), HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h3000_0000, HSIZE_WORD, 1'b0, 32'h0);
        add_row(gpio_addr(GPIO_RED_LEDS), HSIZE_WORD, 1'b0, 32'h0);
        add_row(32'h0000_0000, HSIZE_WORD, 1'b0, 32'h0);
        add_row(gpio_addr(GPIO_RED_LEDS), HSIZE_WORD, 1'b1, 32'h0002_AAAA);
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        rst      <= 1'b0;
        switches <= sw_value;
        buttons  <= btn_value;

        start_test();
        @(negedge clk);
        check_leds(red_leds, green_leds, '0, '0);
        check_count += 2;
        if (spi_cs !== 1'b1)
        begin
            error_count++;
            $display("spi_cs is not high after reset");
        end
        if (spi_sck !== 1'b0)
        begin
            error_count++;
            $display("spi_sck is not low after reset");
        end
        read_word(gpio_addr(GPIO_LIGHT), got);
        check_light(got, '0);
        finish_test("reset");

        start_test();
        for (int k = 0; k < FRAME_COUNT; k++)
        begin
            poll_light(LIGHT_FRAMES[k*LIGHT_WIDTH +: LIGHT_WIDTH], FRAME_LEN, got);
            check_light(got, LIGHT_FRAMES[k*LIGHT_WIDTH +: LIGHT_WIDTH]);
        end
        finish_test("light_frames");

        start_test();
        run_rows(0, words_end);
        finish_test("ram_words");
        start_test();
        run_rows(words_end, lanes_end);
        finish_test("ram_lanes");
        start_test();
        run_rows(lanes_end, bypass_end);
        finish_test("ram_bypass");
        start_test();
        run_rows(bypass_end, rows.size());
        finish_test("gpio");

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog sized from the table and the sensor frame length
    initial
    begin
        int limit;
        wait (table_ready);
        limit = rows.size() * 10 + 3 * FRAME_LEN;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d clock periods", limit);
        $display("test failed");
        $finish;
    end

endmodule
